// File: filelist.f
hw/accel_pkg.sv
hw/pingpong_buffer.sv
hw/layer_sequencer.sv
hw/buffer_pea_mux.sv
hw/pe_array.sv
hw/accel_top.sv
tests/tb_clock.sv
tests/tb_accel.sv

// File: Makefile
TOP := tb_accel

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: tests/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;

    localparam int n_rows      = 10;
    localparam int cycle_limit = n_rows * 80;   // Engine cycles over all rows

    typedef struct packed {
        accel_pkg::comp_sel_e sel;
        logic                 ping_pong;
        accel_pkg::len_t      len;
        accel_pkg::data_t     seed_off;
        logic                 restart;          // Second start pulse while busy
    } row_t;

    localparam row_t layer_table [n_rows] = '{
        '{accel_pkg::sel_conv,  1'b1, 5'd8,  16'h0000, 1'b0},
        '{accel_pkg::sel_conv,  1'b0, 5'd12, 16'h0000, 1'b0},
        '{accel_pkg::sel_conv,  1'b1, 5'd16, 16'h00ff, 1'b0},
        '{accel_pkg::sel_dense, 1'b1, 5'd16, 16'h0000, 1'b0},
        '{accel_pkg::sel_dense, 1'b0, 5'd5,  16'h0f0f, 1'b0},
        '{accel_pkg::sel_pool,  1'b1, 5'd16, 16'h0000, 1'b0},
        '{accel_pkg::sel_pool,  1'b0, 5'd4,  16'h1234, 1'b0},
        '{accel_pkg::sel_idle,  1'b1, 5'd6,  16'h0000, 1'b0},
        '{accel_pkg::sel_conv,  1'b0, 5'd10, 16'h0000, 1'b1},
        '{accel_pkg::sel_pool,  1'b1, 5'd8,  16'h00aa, 1'b1}
    };

    logic                 clk, reset, start, ping_pong, busy, done;
    logic                 host_wr, host_rd, host_buf_sel;
    logic [2:0]           host_bank;
    accel_pkg::comp_sel_e comp_sel;
    accel_pkg::len_t      len;
    accel_pkg::addr_t     host_addr;
    accel_pkg::data_t     host_wr_data, host_rd_data;

    accel_pkg::data_t model [2][accel_pkg::n_buf][accel_pkg::buf_depth];  // buf1, buf2
    int   error_count   = 0;
    int   check_count   = 0;
    int   engine_cycles = 0;
    logic waiting       = 1'b0;

    tb_clock u_clock (.clk, .reset);

    accel_top uut (
        .clk, .reset, .start, .comp_sel, .ping_pong, .len, .host_wr, .host_rd,
        .host_buf_sel, .host_bank, .host_addr, .host_wr_data, .host_rd_data, .busy, .done
    );

    // Counts only cycles spent waiting for done
    always @(posedge clk) begin
        if (waiting) engine_cycles++;
        if (engine_cycles > cycle_limit) begin
            $display("Timeout: done did not arrive within %0d engine cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
        end
    endtask

    // One host word; entered and left 1 ns after a rising edge
    task automatic host_access(input logic wr, input int b, input int bank, input int addr,
                               input accel_pkg::data_t wdata, output accel_pkg::data_t rdata);
        host_wr      = wr;
        host_rd      = !wr;
        host_buf_sel = b[0];
        host_bank    = 3'(bank);
        host_addr    = 4'(addr);
        host_wr_data = wdata;
        @(posedge clk);
        #1;
        host_wr = 1'b0;
        host_rd = 1'b0;
        rdata   = host_rd_data;   // Captured at the edge just passed
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model of the three layer kinds
    //////////////////////////////////////////////////////////////////////

    task automatic model_layer(input row_t r);
        int               src;
        int               dst;
        int               n;
        accel_pkg::data_t acc;
        src = r.ping_pong ? 0 : 1;
        dst = 1 - src;
        n   = int'(r.len);
        acc = '0;
        case (r.sel)
            accel_pkg::sel_conv: begin
                for (int a = 1; a < n; a++) begin
                    for (int i = 0; i < accel_pkg::n_pe; i++) begin
                        model[dst][i][a] = model[dst][i][a]
                                         + model[src][i][0] * model[src][i][a];
                    end
                    model[dst][accel_pkg::n_pe][a] = '0;  // Broadcast bank takes the cleared sum
                end
            end
            accel_pkg::sel_dense: begin
                for (int a = 0; a < n; a++) begin
                    for (int i = 0; i < accel_pkg::n_pe; i++) begin
                        acc = acc + model[src][i][a] * model[src][accel_pkg::n_pe][a];
                    end
                end
                for (int b = 0; b < accel_pkg::n_buf; b++) begin
                    model[dst][b][0] = acc;
                end
            end
            accel_pkg::sel_pool: begin
                for (int a = 0; a < n / 2; a++) begin
                    for (int i = 0; i < accel_pkg::n_pe; i++) begin
                        model[dst][i][a] = (model[src][i][2*a] > model[src][i][2*a+1])
                                         ? model[src][i][2*a] : model[src][i][2*a+1];
                    end
                    model[dst][accel_pkg::n_pe][a] = '0;
                end
            end
            default: ;  // Idle run writes nothing
        endcase
    endtask

    task automatic run_layer(input row_t r);
        start     = 1'b1;
        comp_sel  = r.sel;
        ping_pong = r.ping_pong;
        len       = r.len;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        if (r.restart) begin
            // A different layer offered mid-run
            start     = 1'b1;
            comp_sel  = (r.sel == accel_pkg::sel_conv) ? accel_pkg::sel_dense
                                                       : accel_pkg::sel_conv;
            ping_pong = !r.ping_pong;
            len       = 5'd2;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        waiting = 1'b1;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        waiting = 1'b0;
        check_value("busy", 32'(busy), 32'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        accel_pkg::data_t word;
        {start, ping_pong, host_wr, host_rd, host_buf_sel} = '0;
        comp_sel     = accel_pkg::sel_idle;
        len          = 5'd1;
        host_bank    = '0;
        host_addr    = '0;
        host_wr_data = '0;
        void'($urandom(32'h35f0b7c8));
        wait (reset === 1'b0);
        @(posedge clk);
        #1;
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        for (int r = 0; r < n_rows; r++) begin
            $display("Row %0d: sel %0d, ping_pong %0d, len %0d", r, layer_table[r].sel,
                     layer_table[r].ping_pong, layer_table[r].len);
            for (int b = 0; b < 2; b++) begin
                for (int k = 0; k < accel_pkg::n_buf; k++) begin
                    for (int a = 0; a < accel_pkg::buf_depth; a++) begin
                        model[b][k][a] = accel_pkg::data_t'($urandom()) + layer_table[r].seed_off;
                        host_access(1'b1, b, k, a, model[b][k][a], word);
                    end
                end
            end
            model_layer(layer_table[r]);
            run_layer(layer_table[r]);
            for (int b = 0; b < 2; b++) begin      // Source and destination both
                for (int k = 0; k < accel_pkg::n_buf; k++) begin
                    for (int a = 0; a < accel_pkg::buf_depth; a++) begin
                        host_access(1'b0, b, k, a, '0, word);
                        check_value($sformatf("buf%0d[%0d][%0d]", b + 1, k, a),
                                    32'(word), 32'(model[b][k][a]));
                    end
                end
            end
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // Held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: hw/accel_top.sv
`timescale 1ns/1ps

module accel_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  accel_pkg::comp_sel_e  comp_sel,
    input  logic                  ping_pong,     // 1 makes buf1 the source
    input  accel_pkg::len_t       len,
    input  logic                  host_wr,
    input  logic                  host_rd,
    input  logic                  host_buf_sel,  // 0 picks buf1, 1 picks buf2
    input  logic [2:0]            host_bank,
    input  accel_pkg::addr_t      host_addr,
    input  accel_pkg::data_t      host_wr_data,
    output accel_pkg::data_t      host_rd_data,
    output logic                  busy,
    output logic                  done
);

    accel_pkg::comp_sel_e active_sel;
    accel_pkg::buf_ctrl_t conv_b1, conv_b2, dense_b1, dense_b2, pool_b1, pool_b2;
    accel_pkg::buf_ctrl_t buf1_ctrl, buf2_ctrl;
    accel_pkg::pea_ctrl_t conv_pea, dense_pea, pool_pea, pea_ctrl;
    accel_pkg::steer_e    conv_steer, dense_steer, pool_steer;
    accel_pkg::buf_bus_t  buf1_rd, buf2_rd, buf1_wr, buf2_wr;
    accel_pkg::pe_bus_t   in1, in2, pe_result;
    accel_pkg::data_t     bcast, dense_sum, buf1_host_rd, buf2_host_rd;

    layer_sequencer u_seq (
        .clk, .reset, .start, .comp_sel, .ping_pong, .len, .busy, .done,
        .active_sel      (active_sel),
        .conv_buf1_ctrl  (conv_b1),  .conv_buf2_ctrl  (conv_b2),
        .conv_pea_ctrl   (conv_pea), .conv_steer      (conv_steer),
        .dense_buf1_ctrl (dense_b1), .dense_buf2_ctrl (dense_b2),
        .dense_pea_ctrl  (dense_pea), .dense_steer    (dense_steer),
        .pool_buf1_ctrl  (pool_b1),  .pool_buf2_ctrl  (pool_b2),
        .pool_pea_ctrl   (pool_pea), .pool_steer      (pool_steer)
    );

    buffer_pea_mux u_mux (
        .comp_sel        (active_sel),
        .conv_buf1_ctrl  (conv_b1),  .conv_buf2_ctrl  (conv_b2),
        .conv_pea_ctrl   (conv_pea), .conv_steer      (conv_steer),
        .dense_buf1_ctrl (dense_b1), .dense_buf2_ctrl (dense_b2),
        .dense_pea_ctrl  (dense_pea), .dense_steer    (dense_steer),
        .pool_buf1_ctrl  (pool_b1),  .pool_buf2_ctrl  (pool_b2),
        .pool_pea_ctrl   (pool_pea), .pool_steer      (pool_steer),
        .buf1_rd, .buf2_rd, .pe_result, .dense_sum,
        .buf1_ctrl, .buf2_ctrl, .buf1_wr, .buf2_wr, .pea_ctrl, .in1, .in2, .bcast
    );

    pe_array u_pea (
        .clk, .reset, .ctrl (pea_ctrl), .in1, .in2, .bcast,
        .result (pe_result), .dense_sum
    );

    pingpong_buffer u_buf1 (
        .clk, .ctrl (buf1_ctrl), .wr_bus (buf1_wr),
        .host_wr (host_wr && !host_buf_sel), .host_rd (host_rd && !host_buf_sel),
        .host_bank, .host_addr, .host_wr_data,
        .rd_bus (buf1_rd), .host_rd_data (buf1_host_rd)
    );

    pingpong_buffer u_buf2 (
        .clk, .ctrl (buf2_ctrl), .wr_bus (buf2_wr),
        .host_wr (host_wr && host_buf_sel), .host_rd (host_rd && host_buf_sel),
        .host_bank, .host_addr, .host_wr_data,
        .rd_bus (buf2_rd), .host_rd_data (buf2_host_rd)
    );

    // Unselected buffer returns zero
    assign host_rd_data = buf1_host_rd | buf2_host_rd;

endmodule

// File: hw/pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                 clk,
    input  logic                 reset,
    input  accel_pkg::pea_ctrl_t ctrl,
    input  accel_pkg::pe_bus_t   in1,
    input  accel_pkg::pe_bus_t   in2,
    input  accel_pkg::data_t     bcast,
    output accel_pkg::pe_bus_t   result,
    output accel_pkg::data_t     dense_sum
);

    accel_pkg::pe_bus_t weight;
    accel_pkg::pe_bus_t mac_out;
    accel_pkg::pe_bus_t max_out;
    accel_pkg::data_t   dense_step;

    //////////////////////////////////////////////////////////////////////
    // Lane datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dense_step = '0;
        for (int i = 0; i < accel_pkg::n_pe; i++) begin
            mac_out[i] = (ctrl.feedback_enable ? in2[i] : 16'd0)
                       + accel_pkg::data_t'(weight[i] * in1[i]);
            max_out[i] = (in1[i] > result[i]) ? in1[i] : result[i];
            dense_step = dense_step + accel_pkg::data_t'(in1[i] * bcast);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < accel_pkg::n_pe; i++) begin
            if (ctrl.load_weight) weight[i] <= in1[i];
            if (ctrl.out_valid) begin
                if (ctrl.mac_enable) begin
                    result[i] <= mac_out[i];
                end else if (ctrl.pool_enable) begin
                    result[i] <= ctrl.pool_first ? in1[i] : max_out[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Dense reduction lane
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || ctrl.dense_clear) begin
            dense_sum <= '0;                        // Clear wins over enable
        end else if (ctrl.dense_enable && ctrl.out_valid) begin
            dense_sum <= dense_sum + dense_step;    // Wraps at 16 bits
        end
    end

endmodule

// File: hw/buffer_pea_mux.sv
`timescale 1ns/1ps

module buffer_pea_mux (
    input  accel_pkg::comp_sel_e  comp_sel,
    input  accel_pkg::buf_ctrl_t  conv_buf1_ctrl,
    input  accel_pkg::buf_ctrl_t  conv_buf2_ctrl,
    input  accel_pkg::pea_ctrl_t  conv_pea_ctrl,
    input  accel_pkg::steer_e     conv_steer,
    input  accel_pkg::buf_ctrl_t  dense_buf1_ctrl,
    input  accel_pkg::buf_ctrl_t  dense_buf2_ctrl,
    input  accel_pkg::pea_ctrl_t  dense_pea_ctrl,
    input  accel_pkg::steer_e     dense_steer,
    input  accel_pkg::buf_ctrl_t  pool_buf1_ctrl,
    input  accel_pkg::buf_ctrl_t  pool_buf2_ctrl,
    input  accel_pkg::pea_ctrl_t  pool_pea_ctrl,
    input  accel_pkg::steer_e     pool_steer,
    input  accel_pkg::buf_bus_t   buf1_rd,
    input  accel_pkg::buf_bus_t   buf2_rd,
    input  accel_pkg::pe_bus_t    pe_result,
    input  accel_pkg::data_t      dense_sum,
    output accel_pkg::buf_ctrl_t  buf1_ctrl,
    output accel_pkg::buf_ctrl_t  buf2_ctrl,
    output accel_pkg::buf_bus_t   buf1_wr,
    output accel_pkg::buf_bus_t   buf2_wr,
    output accel_pkg::pea_ctrl_t  pea_ctrl,
    output accel_pkg::pe_bus_t    in1,
    output accel_pkg::pe_bus_t    in2,
    output accel_pkg::data_t      bcast
);

    accel_pkg::steer_e   steer;
    accel_pkg::buf_bus_t src_rd, oth_rd, wr_bus;
    logic                src_is_buf1, dense_route;

    //////////////////////////////////////////////////////////////////////
    // Control select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (comp_sel)
            accel_pkg::sel_conv: begin
                buf1_ctrl = conv_buf1_ctrl;
                buf2_ctrl = conv_buf2_ctrl;
                pea_ctrl  = conv_pea_ctrl;
                steer     = conv_steer;
            end
            accel_pkg::sel_dense: begin
                buf1_ctrl = dense_buf1_ctrl;
                buf2_ctrl = dense_buf2_ctrl;
                pea_ctrl  = dense_pea_ctrl;
                steer     = dense_steer;
            end
            accel_pkg::sel_pool: begin
                buf1_ctrl = pool_buf1_ctrl;
                buf2_ctrl = pool_buf2_ctrl;
                pea_ctrl  = pool_pea_ctrl;
                steer     = pool_steer;
            end
            default: begin                  // Idle gives safe zeros
                buf1_ctrl            = '0;
                buf2_ctrl            = '0;
                pea_ctrl             = '0;
                pea_ctrl.dense_clear = 1'b1;
                steer                = accel_pkg::aybz;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Data steering
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (steer)
            accel_pkg::azby: begin src_is_buf1 = 1'b0; dense_route = 1'b0; end
            accel_pkg::aybz: begin src_is_buf1 = 1'b1; dense_route = 1'b0; end
            accel_pkg::bybz: begin src_is_buf1 = 1'b0; dense_route = 1'b1; end
            default:         begin src_is_buf1 = 1'b1; dense_route = 1'b1; end
        endcase

        src_rd = src_is_buf1 ? buf1_rd : buf2_rd;
        oth_rd = src_is_buf1 ? buf2_rd : buf1_rd;

        for (int i = 0; i < accel_pkg::n_pe; i++) begin
            in1[i]    = src_rd[i];     // Conv input or dense weights
            in2[i]    = oth_rd[i];     // Feedback from the destination
            wr_bus[i] = dense_route ? dense_sum : pe_result[i];
        end
        bcast                  = src_rd[accel_pkg::n_pe];  // Dense input vector
        wr_bus[accel_pkg::n_pe] = dense_sum;               // Zero outside dense
    end

    // Only the destination has w_en, so both can share one bus
    assign buf1_wr = wr_bus;
    assign buf2_wr = wr_bus;

endmodule

// File: hw/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  accel_pkg::comp_sel_e  comp_sel,
    input  logic                  ping_pong,
    input  accel_pkg::len_t       len,
    output logic                  busy,
    output logic                  done,
    output accel_pkg::comp_sel_e  active_sel,
    output accel_pkg::buf_ctrl_t  conv_buf1_ctrl,
    output accel_pkg::buf_ctrl_t  conv_buf2_ctrl,
    output accel_pkg::pea_ctrl_t  conv_pea_ctrl,
    output accel_pkg::steer_e     conv_steer,
    output accel_pkg::buf_ctrl_t  dense_buf1_ctrl,
    output accel_pkg::buf_ctrl_t  dense_buf2_ctrl,
    output accel_pkg::pea_ctrl_t  dense_pea_ctrl,
    output accel_pkg::steer_e     dense_steer,
    output accel_pkg::buf_ctrl_t  pool_buf1_ctrl,
    output accel_pkg::buf_ctrl_t  pool_buf2_ctrl,
    output accel_pkg::pea_ctrl_t  pool_pea_ctrl,
    output accel_pkg::steer_e     pool_steer
);

    accel_pkg::seq_state_e state;
    accel_pkg::comp_sel_e  sel_q;
    accel_pkg::len_t       len_q;
    accel_pkg::addr_t      rd_addr, d1_addr, d2_addr;
    accel_pkg::buf_ctrl_t  conv_src, conv_dst, dense_src, dense_dst, pool_src, pool_dst;
    logic                  pp_q;
    logic                  rd_fire, rd_last;
    logic                  d1_valid, d1_last, d2_valid, d2_last;

    assign busy       = state != accel_pkg::st_idle;
    assign active_sel = busy ? sel_q : accel_pkg::sel_idle;
    assign rd_fire    = state == accel_pkg::st_run;  // One read per cycle
    assign rd_last    = {1'b0, rd_addr} == len_q - 5'd1;

    //////////////////////////////////////////////////////////////////////
    // State machine and read counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= accel_pkg::st_idle;
            sel_q    <= accel_pkg::sel_idle;
            pp_q     <= 1'b0;
            len_q    <= 5'd1;
            rd_addr  <= '0;
            d1_valid <= 1'b0;
            d2_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            d1_valid <= rd_fire;                 // Buffer data stage
            d2_valid <= d1_valid;                // PE result stage
            done     <= d2_valid && d2_last;     // Cycle after the last write
            case (state)
                accel_pkg::st_idle: begin
                    if (start) begin
                        state   <= accel_pkg::st_run;
                        sel_q   <= comp_sel;
                        pp_q    <= ping_pong;
                        len_q   <= len;
                        rd_addr <= '0;
                    end
                end
                accel_pkg::st_run: begin
                    rd_addr <= rd_addr + 4'd1;
                    if (rd_last) state <= accel_pkg::st_drain;
                end
                default: begin
                    if (d2_valid && d2_last) state <= accel_pkg::st_idle;
                end
            endcase
        end
    end

    // Address delay line follows the valid bits
    always_ff @(posedge clk) begin
        d1_addr <= rd_addr;
        d1_last <= rd_last;
        d2_addr <= d1_addr;
        d2_last <= d1_last;
    end

    //////////////////////////////////////////////////////////////////////
    // Per-mode schedules
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Conv reads both buffers and writes back at the delayed address
        conv_src = '{r_en: rd_fire, r_addr: rd_addr, w_en: 1'b0, w_addr: '0};
        conv_dst = '{r_en: rd_fire, r_addr: rd_addr,
                     w_en: d2_valid && d2_addr != '0, w_addr: d2_addr};
        dense_src = '{r_en: rd_fire, r_addr: rd_addr, w_en: 1'b0, w_addr: '0};
        dense_dst = '{r_en: 1'b0, r_addr: '0, w_en: d2_valid && d2_last, w_addr: '0};
        pool_src  = '{r_en: rd_fire, r_addr: rd_addr, w_en: 1'b0, w_addr: '0};
        pool_dst  = '{r_en: 1'b0, r_addr: '0,
                      w_en: d2_valid && d2_addr[0], w_addr: d2_addr >> 1};

        conv_pea_ctrl                 = '0;
        conv_pea_ctrl.load_weight     = d1_valid && d1_addr == '0;  // Step 0
        conv_pea_ctrl.mac_enable      = d1_valid && d1_addr != '0;
        conv_pea_ctrl.feedback_enable = d1_valid && d1_addr != '0;
        conv_pea_ctrl.dense_clear     = 1'b1;   // Keeps broadcast bank writes at zero
        conv_pea_ctrl.out_valid       = d1_valid;

        dense_pea_ctrl              = '0;
        dense_pea_ctrl.dense_enable = d1_valid;
        dense_pea_ctrl.dense_clear  = !d1_valid;
        dense_pea_ctrl.out_valid    = d1_valid;

        pool_pea_ctrl             = '0;
        pool_pea_ctrl.pool_enable = d1_valid;
        pool_pea_ctrl.pool_first  = d1_valid && !d1_addr[0];  // Even reads
        pool_pea_ctrl.dense_clear = 1'b1;
        pool_pea_ctrl.out_valid   = d1_valid;
    end

    // Source and destination mapped by ping-pong direction
    assign conv_buf1_ctrl  = pp_q ? conv_src : conv_dst;
    assign conv_buf2_ctrl  = pp_q ? conv_dst : conv_src;
    assign dense_buf1_ctrl = pp_q ? dense_src : dense_dst;
    assign dense_buf2_ctrl = pp_q ? dense_dst : dense_src;
    assign pool_buf1_ctrl  = pp_q ? pool_src : pool_dst;
    assign pool_buf2_ctrl  = pp_q ? pool_dst : pool_src;

    assign conv_steer  = pp_q ? accel_pkg::aybz : accel_pkg::azby;
    assign dense_steer = pp_q ? accel_pkg::ayaz : accel_pkg::bybz;
    assign pool_steer  = pp_q ? accel_pkg::aybz : accel_pkg::azby;

    // A start during a run does not begin a fresh read sweep
    a_start_ignored: assert property (@(posedge clk) disable iff (reset)
        start && busy |=> !(state == accel_pkg::st_run && rd_addr == '0));

endmodule

// File: hw/pingpong_buffer.sv
`timescale 1ns/1ps

module pingpong_buffer (
    input  logic                 clk,
    input  accel_pkg::buf_ctrl_t ctrl,
    input  accel_pkg::buf_bus_t  wr_bus,
    input  logic                 host_wr,      // Already qualified by buffer select
    input  logic                 host_rd,
    input  logic [2:0]           host_bank,
    input  accel_pkg::addr_t     host_addr,
    input  accel_pkg::data_t     host_wr_data,
    output accel_pkg::buf_bus_t  rd_bus,
    output accel_pkg::data_t     host_rd_data
);

    accel_pkg::data_t mem [accel_pkg::n_buf][accel_pkg::buf_depth];

    logic host_bank_ok;

    assign host_bank_ok = host_bank < 3'(accel_pkg::n_buf);

    // Engine port works on all banks at one shared address
    always_ff @(posedge clk) begin
        for (int b = 0; b < accel_pkg::n_buf; b++) begin
            if (ctrl.w_en) begin
                mem[b][ctrl.w_addr] <= wr_bus[b];
            end
            if (ctrl.r_en) begin
                rd_bus[b] <= mem[b][ctrl.r_addr];  // Registered slice
            end
        end
        // Host writes one word at a time
        if (host_wr && host_bank_ok) begin
            mem[host_bank][host_addr] <= host_wr_data;
        end
    end

    // Host read port
    always_ff @(posedge clk) begin
        // Zero when not read so the top can OR both buffers
        if (host_rd && host_bank_ok) begin
            host_rd_data <= mem[host_bank][host_addr];
        end else begin
            host_rd_data <= '0;
        end
    end

    // Host loads only while the engine leaves the buffer alone
    a_no_write_clash: assert property (@(posedge clk) !(host_wr && ctrl.w_en));

endmodule

// File: hw/accel_pkg.sv
package accel_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Sizes
    ///////////////////////////////////////////////////////////////////////

    localparam int n_pe      = 4;
    localparam int n_buf     = n_pe + 1;   // Bank n_pe is the broadcast bank
    localparam int buf_depth = 16;

    typedef logic [15:0] data_t;
    typedef logic [3:0]  addr_t;
    typedef logic [4:0]  len_t;            // Layer length 1 to 16

    ///////////////////////////////////////////////////////////////////////
    // Modes and states
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        sel_idle  = 3'd0,
        sel_conv  = 3'd1,
        sel_dense = 3'd2,
        sel_pool  = 3'd3
    } comp_sel_e;

    // A is buf1 out, B is buf2 out, Y is PE input 1, Z is PE input 2
    typedef enum logic [1:0] {
        azby = 2'd0,   // conv/pool with buf2 as source
        aybz = 2'd1,   // conv/pool with buf1 as source
        bybz = 2'd2,   // dense with buf2 as source
        ayaz = 2'd3    // dense with buf1 as source
    } steer_e;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } seq_state_e;

    ///////////////////////////////////////////////////////////////////////
    // Control and data bundles
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  r_en;
        addr_t r_addr;
        logic  w_en;
        addr_t w_addr;
    } buf_ctrl_t;

    typedef struct packed {
        logic load_weight;      // Latch per-lane weight
        logic mac_enable;
        logic feedback_enable;  // Add in2 to the product
        logic pool_enable;
        logic pool_first;       // First word of a max pair
        logic dense_enable;
        logic dense_clear;
        logic out_valid;
    } pea_ctrl_t;

    typedef data_t [n_buf-1:0] buf_bus_t;
    typedef data_t [n_pe-1:0]  pe_bus_t;

endpackage
